// ==== all.f ====
+incdir+sim
verilog/merge_pkg.sv
verilog/blk_writer.sv
verilog/blk_fifo.sv
verilog/merge_select.sv
verilog/out_stage.sv
verilog/merge_ram_top.sv
sim/tb_merge_ram.sv

// ==== run.sh ====
#!/bin/sh
# builds the merge testbench with Verilator and runs it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_merge_ram -o tb_merge_ram
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_merge_ram
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// ==== sim/tb_merge_checks.svh ====
// included in the body of tb_merge_ram; uses its expected arrays, pointers and counters
`ifndef TB_MERGE_CHECKS_SVH
`define TB_MERGE_CHECKS_SVH

  a_out_item: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |-> (out_time_o == exp_time[rd_ptr] &&
      out_blk_o == exp_blk[rd_ptr] && out_pay_o == exp_pay[rd_ptr]))
    else fail_value("output item differs from the expected time, block or payload");

  // upper bits carry the frame start time
  a_out_base: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> (out_time_o[BASE_W+KEY_W-1 -: BASE_W] == exp_base[out_frame]))
    else fail_value("base time in out_time_o differs from the frame base");

  a_out_last: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |-> (out_last_o == exp_last[rd_ptr]))
    else fail_value("out_last_o is wrong for this item");

  a_frame_len: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i && out_last_o) |-> (out_cnt + 1 == exp_words[out_frame]))
    else fail_value("frame length differs from the words sent");

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable({out_time_o, out_blk_o, out_pay_o, out_last_o})))
    else fail_value("output changed while stalled");

  a_in_stall: assert property (@(posedge clk) disable iff (rst)
    (pending_items > 0) |-> !in_ready_o)
    else fail_value("in_ready_o high while a frame is still merging");

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> (in_ready_o && !out_valid_o))
    else fail_value("wrong in_ready_o or out_valid_o after reset");

`endif

// ==== sim/tb_merge_ram.sv ====
// random frames of 4 blocks with 1..8 words each; the expected order is rebuilt by sorting every frame
`timescale 1ns/1ps

module tb_merge_ram;

  localparam int NUM_BLK_W  = merge_pkg::NUM_BLK_W;
  localparam int KEY_W      = merge_pkg::KEY_W;
  localparam int PAY_W      = merge_pkg::PAY_W;
  localparam int BASE_W     = merge_pkg::BASE_W;
  localparam int FIFO_AW    = merge_pkg::FIFO_AW;
  localparam int NB         = 2**NUM_BLK_W;
  localparam int NUM_FRAMES = 20;
  localparam int MAX_WORDS  = 8;  // per block
  localparam int EXP_DEPTH  = NUM_FRAMES * NB * MAX_WORDS + 1;

  logic clk, rst, in_valid_i, in_last_i, in_ready_o, out_ready_i;
  logic out_valid_o, out_last_o;
  logic [BASE_W-1:0]       in_base_i;
  logic [KEY_W-1:0]        in_key_i;
  logic [PAY_W-1:0]        in_pay_i;
  logic [BASE_W+KEY_W-1:0] out_time_o;
  logic [NUM_BLK_W-1:0]    out_blk_o;
  logic [PAY_W-1:0]        out_pay_o;

  int seed = 32'h1550d07a;

  // expected items in merge order, plus per-frame base and length
  logic [BASE_W+KEY_W-1:0] exp_time [EXP_DEPTH];
  logic [NUM_BLK_W-1:0]    exp_blk [EXP_DEPTH];
  logic [PAY_W-1:0]        exp_pay [EXP_DEPTH];
  logic                    exp_last [EXP_DEPTH];
  logic [BASE_W-1:0]       exp_base [NUM_FRAMES+1];
  int                      exp_words [NUM_FRAMES+1];
  int wr_ptr = 0;
  int rd_ptr = 0;
  int committed = 0;  // items of frames whose input is complete
  int frame_end = 0;
  int out_frame = 0;
  int out_cnt = 0;
  int drv_blk = 0;
  int pending_items;

  // current frame in input order
  logic [KEY_W-1:0] fr_key [NB*MAX_WORDS];
  int               fr_blk [NB*MAX_WORDS];
  logic [PAY_W-1:0] fr_pay [NB*MAX_WORDS];
  logic             fr_last [NB*MAX_WORDS];
  logic [BASE_W-1:0] fr_base;
  int               fr_len;

  merge_ram_top #(.NUM_BLK_W(NUM_BLK_W), .KEY_W(KEY_W), .PAY_W(PAY_W), .BASE_W(BASE_W),
    .FIFO_AW(FIFO_AW)) u_merge_ram_top (
    .clk(clk), .rst(rst), .in_valid_i(in_valid_i), .in_last_i(in_last_i),
    .in_base_i(in_base_i), .in_key_i(in_key_i), .in_pay_i(in_pay_i), .in_ready_o(in_ready_o),
    .out_valid_o(out_valid_o), .out_time_o(out_time_o), .out_blk_o(out_blk_o),
    .out_pay_o(out_pay_o), .out_last_o(out_last_o), .out_ready_i(out_ready_i)
  );

  task automatic fail_value(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  `include "tb_merge_checks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign pending_items = committed - rd_ptr - int'(out_valid_o);  // still inside the fifos

  always @(posedge clk) begin
    if (out_valid_o && out_ready_i) begin
      rd_ptr <= rd_ptr + 1;
      out_cnt <= out_last_o ? 0 : out_cnt + 1;
      if (out_last_o)
        out_frame <= out_frame + 1;
    end
    if (in_valid_i && in_ready_o && in_last_i && drv_blk == NB-1)
      committed <= frame_end;
  end

  // random back-pressure on the output
  initial begin
    out_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      out_ready_i = (($unsigned($random(seed)) % 4) != 0);
    end
  end

  task automatic build_frame(input int f);
    int order [NB*MAX_WORDS];
    int n;
    int k;
    int len;
    int tmp;
    int j;
    fr_base = BASE_W'($unsigned($random(seed)));
    n = 0;
    for (int b = 0; b < NB; b++) begin
      len = 1 + int'($unsigned($random(seed)) % MAX_WORDS);
      k = int'($unsigned($random(seed)) % 16);
      for (int w = 0; w < len; w++) begin
        k = k + int'($unsigned($random(seed)) % 4);  // keys never drop inside a block
        if (k > 2**KEY_W-1)
          k = 2**KEY_W-1;
        fr_key[n] = KEY_W'(k);
        fr_blk[n] = b;
        fr_pay[n] = PAY_W'($unsigned($random(seed)));
        fr_last[n] = (w == len-1);
        order[n] = (k << 16) | (b << 8) | n;  // key, then block, then arrival
        n++;
      end
    end
    for (int i = 1; i < n; i++) begin
      tmp = order[i];
      j = i - 1;
      while (j >= 0 && order[j] > tmp) begin
        order[j+1] = order[j];
        j--;
      end
      order[j+1] = tmp;
    end
    for (int i = 0; i < n; i++) begin
      j = order[i] & 8'hff;
      exp_time[wr_ptr] = {fr_base, fr_key[j]};
      exp_blk[wr_ptr] = NUM_BLK_W'(fr_blk[j]);
      exp_pay[wr_ptr] = fr_pay[j];
      exp_last[wr_ptr] = (i == n-1);
      wr_ptr++;
    end
    exp_base[f] = fr_base;
    exp_words[f] = n;
    frame_end = wr_ptr;
    fr_len = n;
  endtask

  task automatic send_frame();
    for (int i = 0; i < fr_len; i++) begin
      while (($unsigned($random(seed)) % 4) == 0) begin  // idle gap
        @(negedge clk);
        in_valid_i = 1'b0;
      end
      @(negedge clk);
      drv_blk = fr_blk[i];
      in_valid_i = 1'b1;
      in_last_i = fr_last[i];
      in_base_i = fr_base;
      in_key_i = fr_key[i];
      in_pay_i = fr_pay[i];
      while (!in_ready_o)
        @(negedge clk);
      @(posedge clk);
    end
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    in_valid_i = 1'b0;
    in_last_i = 1'b0;
    in_base_i = '0;
    in_key_i = '0;
    in_pay_i = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      build_frame(f);
      send_frame();
    end
    wait (out_frame == NUM_FRAMES);
    @(negedge clk);
    if (rd_ptr == wr_ptr) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_value("number of output items differs from the words sent");
    end
  end

  initial begin
    repeat (NUM_FRAMES * 200 + 10) @(posedge clk);
    $display("timeout: the merged frames did not all come out in time");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verilog/blk_fifo.sv ====
// first-word-fall-through fifo; writing when full or popping when empty is an error
`timescale 1ns/1ps

module blk_fifo #(
  parameter int FIFO_AW = merge_pkg::FIFO_AW,
  parameter int W       = merge_pkg::KEY_W + merge_pkg::PAY_W
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         wr_i,
  input  logic [W-1:0] din_i,
  input  logic         rd_i,
  output logic [W-1:0] dout_o,
  output logic         empty_o,
  output logic         full_o
);

  localparam int DEPTH = 2**FIFO_AW;

  logic [W-1:0]       mem [DEPTH];
  logic [FIFO_AW-1:0] wp;
  logic [FIFO_AW-1:0] rp;
  logic [FIFO_AW:0]   cnt;  // occupancy

  assign dout_o  = mem[rp];  // head shown without a read cycle
  assign empty_o = (cnt == '0);
  assign full_o  = cnt[FIFO_AW];

  always_ff @(posedge clk) begin
    if (wr_i)
      mem[wp] <= din_i;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wp  <= '0;
      rp  <= '0;
      cnt <= '0;
    end else begin
      if (wr_i)
        wp <= wp + 1'b1;
      if (rd_i)
        rp <= rp + 1'b1;
      case ({wr_i, rd_i})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_i |-> !empty_o);

endmodule

// ==== verilog/blk_writer.sv ====
// blocks of a frame must arrive in order 0..N-1, each with 1..2^FIFO_AW words; input stalls while merging
`timescale 1ns/1ps

module blk_writer #(
  parameter int NUM_BLK_W = merge_pkg::NUM_BLK_W,
  parameter int KEY_W     = merge_pkg::KEY_W,
  parameter int PAY_W     = merge_pkg::PAY_W,
  parameter int BASE_W    = merge_pkg::BASE_W
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  input  logic                    in_last_i,
  input  logic [BASE_W-1:0]       in_base_i,
  input  logic [KEY_W-1:0]        in_key_i,
  input  logic [PAY_W-1:0]        in_pay_i,
  input  logic [2**NUM_BLK_W-1:0] fifo_full_i,
  input  logic                    merging_i,
  output logic                    in_ready_o,
  output logic [2**NUM_BLK_W-1:0] wr_en_o,
  output logic [KEY_W-1:0]        wr_key_o,
  output logic [PAY_W-1:0]        wr_pay_o,
  output logic [BASE_W-1:0]       base_o,
  output logic                    frame_done_o
);

  localparam int NB = 2**NUM_BLK_W;

  logic [NUM_BLK_W-1:0] blk_cnt;  // current block, selects the fifo
  logic                 first_q;  // next word opens a frame
  logic [BASE_W-1:0]    base_q;
  logic                 xfer;

  assign in_ready_o   = !merging_i && !fifo_full_i[blk_cnt];
  assign xfer         = in_valid_i && in_ready_o;
  assign frame_done_o = xfer && in_last_i && (&blk_cnt);  // last word of last block

  assign wr_en_o  = xfer ? ({{(NB-1){1'b0}}, 1'b1} << blk_cnt) : '0;
  assign wr_key_o = in_key_i;
  assign wr_pay_o = in_pay_i;
  assign base_o   = base_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      blk_cnt <= '0;
      first_q <= 1'b1;
    end else if (xfer) begin
      if (in_last_i)
        blk_cnt <= blk_cnt + 1'b1;  // wraps after the final block
      first_q <= frame_done_o;
    end
  end

  // father-domain start time, held through the merge
  always_ff @(posedge clk) begin
    if (xfer && first_q)
      base_q <= in_base_i;
  end

  // a merge only runs on a complete frame
  a_merge_after_frame: assert property (@(posedge clk) disable iff (rst)
    merging_i |-> (blk_cnt == '0 && first_q));

endmodule

// ==== verilog/merge_pkg.sv ====
// defaults for the block merge; the top level overrides these through module parameters
package merge_pkg;

  // log2 of blocks per frame
  parameter int NUM_BLK_W = 2;

  // local time key width
  parameter int KEY_W = 6;

  // payload width
  parameter int PAY_W = 16;

  // base time index width
  parameter int BASE_W = 8;

  // block fifo address width, 16 entries
  parameter int FIFO_AW = 4;

  // selector states
  typedef enum logic [0:0] {
    ST_FILL  = 1'b0,
    ST_MERGE = 1'b1
  } merge_state_e;

endpackage

// ==== verilog/merge_ram_top.sv ====
// merges 2^NUM_BLK_W key-ordered blocks into one time-ordered frame; empty frames are not supported
`timescale 1ns/1ps

module merge_ram_top #(
  parameter int NUM_BLK_W = merge_pkg::NUM_BLK_W,
  parameter int KEY_W     = merge_pkg::KEY_W,
  parameter int PAY_W     = merge_pkg::PAY_W,
  parameter int BASE_W    = merge_pkg::BASE_W,
  parameter int FIFO_AW   = merge_pkg::FIFO_AW
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  input  logic                    in_last_i,
  input  logic [BASE_W-1:0]       in_base_i,
  input  logic [KEY_W-1:0]        in_key_i,
  input  logic [PAY_W-1:0]        in_pay_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output logic [BASE_W+KEY_W-1:0] out_time_o,
  output logic [NUM_BLK_W-1:0]    out_blk_o,
  output logic [PAY_W-1:0]        out_pay_o,
  output logic                    out_last_o,
  input  logic                    out_ready_i
);

  localparam int NB = 2**NUM_BLK_W;
  localparam int DW = KEY_W + PAY_W;

  logic [NB-1:0]      wr_en;
  logic [KEY_W-1:0]   wr_key;
  logic [PAY_W-1:0]   wr_pay;
  logic [NB-1:0]      fifo_full;
  logic [NB-1:0]      fifo_empty;
  logic [NB-1:0]      fifo_rd;
  logic [NB*DW-1:0]   heads;  // {key, pay} per block
  logic [BASE_W-1:0]  base;
  logic               frame_done;
  logic               merging;
  logic               sel_valid;
  logic               sel_ready;
  logic [KEY_W-1:0]   sel_key;
  logic [NUM_BLK_W-1:0] sel_blk;
  logic [PAY_W-1:0]   sel_pay;
  logic               sel_last;

  blk_writer #(.NUM_BLK_W(NUM_BLK_W), .KEY_W(KEY_W), .PAY_W(PAY_W), .BASE_W(BASE_W)) u_writer (
    .clk, .rst, .in_valid_i, .in_last_i, .in_base_i, .in_key_i, .in_pay_i,
    .fifo_full_i(fifo_full), .merging_i(merging), .in_ready_o, .wr_en_o(wr_en),
    .wr_key_o(wr_key), .wr_pay_o(wr_pay), .base_o(base), .frame_done_o(frame_done)
  );

  for (genvar g = 0; g < NB; g++) begin : g_fifo
    blk_fifo #(.FIFO_AW(FIFO_AW), .W(DW)) u_fifo (
      .clk, .rst, .wr_i(wr_en[g]), .din_i({wr_key, wr_pay}), .rd_i(fifo_rd[g]),
      .dout_o(heads[g*DW +: DW]), .empty_o(fifo_empty[g]), .full_o(fifo_full[g])
    );
  end

  merge_select #(.NUM_BLK_W(NUM_BLK_W), .KEY_W(KEY_W), .PAY_W(PAY_W), .FIFO_AW(FIFO_AW)) u_sel (
    .clk, .rst, .frame_done_i(frame_done), .wr_i(wr_en), .head_i(heads),
    .empty_i(fifo_empty), .sel_ready_i(sel_ready), .merging_o(merging), .rd_o(fifo_rd),
    .sel_valid_o(sel_valid), .sel_key_o(sel_key), .sel_blk_o(sel_blk),
    .sel_pay_o(sel_pay), .sel_last_o(sel_last)
  );

  out_stage #(.NUM_BLK_W(NUM_BLK_W), .KEY_W(KEY_W), .PAY_W(PAY_W), .BASE_W(BASE_W)) u_out (
    .clk, .rst, .base_i(base), .sel_valid_i(sel_valid), .sel_key_i(sel_key),
    .sel_blk_i(sel_blk), .sel_pay_i(sel_pay), .sel_last_i(sel_last), .out_ready_i,
    .sel_ready_o(sel_ready), .out_valid_o, .out_time_o, .out_blk_o, .out_pay_o, .out_last_o
  );

endmodule

// ==== verilog/merge_select.sv ====
// keys inside each fifo must be nondecreasing; no fifo is written while a merge runs
`timescale 1ns/1ps

module merge_select #(
  parameter int NUM_BLK_W = merge_pkg::NUM_BLK_W,
  parameter int KEY_W     = merge_pkg::KEY_W,
  parameter int PAY_W     = merge_pkg::PAY_W,
  parameter int FIFO_AW   = merge_pkg::FIFO_AW
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  frame_done_i,
  input  logic [2**NUM_BLK_W-1:0]               wr_i,
  input  logic [2**NUM_BLK_W*(KEY_W+PAY_W)-1:0] head_i,
  input  logic [2**NUM_BLK_W-1:0]               empty_i,
  input  logic                                  sel_ready_i,
  output logic                                  merging_o,
  output logic [2**NUM_BLK_W-1:0]               rd_o,
  output logic                                  sel_valid_o,
  output logic [KEY_W-1:0]                      sel_key_o,
  output logic [NUM_BLK_W-1:0]                  sel_blk_o,
  output logic [PAY_W-1:0]                      sel_pay_o,
  output logic                                  sel_last_o
);

  localparam int NB = 2**NUM_BLK_W;
  localparam int DW = KEY_W + PAY_W;

  merge_pkg::merge_state_e state;

  logic [KEY_W-1:0]     key_a [NB];
  logic [PAY_W-1:0]     pay_a [NB];
  logic [FIFO_AW:0]     rem [NB];  // words left per fifo
  logic [NUM_BLK_W-1:0] best;
  logic [KEY_W-1:0]     best_key;
  logic                 found;
  logic [NB-1:0]        nonempty;
  logic                 single;
  logic                 pop;

  // minimum head; strict compare keeps the lower block on ties
  always_comb begin
    found    = 1'b0;
    best     = '0;
    best_key = '0;
    for (int i = 0; i < NB; i++) begin
      key_a[i] = head_i[i*DW+PAY_W +: KEY_W];
      pay_a[i] = head_i[i*DW +: PAY_W];
      if (!empty_i[i] && (!found || key_a[i] < best_key)) begin
        found    = 1'b1;
        best     = NUM_BLK_W'(i);
        best_key = key_a[i];
      end
    end
  end

  assign nonempty    = ~empty_i;
  assign single      = ((nonempty & (nonempty - 1'b1)) == '0);  // at most one fifo left
  assign merging_o   = (state == merge_pkg::ST_MERGE);
  assign sel_valid_o = merging_o && found;
  assign sel_key_o   = best_key;
  assign sel_blk_o   = best;
  assign sel_pay_o   = pay_a[best];
  assign sel_last_o  = sel_valid_o && single && (rem[best] == (FIFO_AW+1)'(1));
  assign pop         = sel_valid_o && sel_ready_i;
  assign rd_o        = pop ? ({{(NB-1){1'b0}}, 1'b1} << best) : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= merge_pkg::ST_FILL;
    end else begin
      case (state)
        merge_pkg::ST_FILL:  if (frame_done_i) state <= merge_pkg::ST_MERGE;
        merge_pkg::ST_MERGE: if (pop && sel_last_o) state <= merge_pkg::ST_FILL;
        default:             state <= merge_pkg::ST_FILL;
      endcase
    end
  end

  // mirrors fifo occupancy from the writes and pops seen here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NB; i++)
        rem[i] <= '0;
    end else begin
      for (int i = 0; i < NB; i++) begin
        if (wr_i[i])
          rem[i] <= rem[i] + 1'b1;
        else if (rd_o[i])
          rem[i] <= rem[i] - 1'b1;
      end
    end
  end

  // merge leaves on the last pop before the fifos run dry
  a_merge_not_dry: assert property (@(posedge clk) disable iff (rst)
    merging_o |-> found);

endmodule

// ==== verilog/out_stage.sv ====
// single output register; time is base then key, captured when the item is loaded
`timescale 1ns/1ps

module out_stage #(
  parameter int NUM_BLK_W = merge_pkg::NUM_BLK_W,
  parameter int KEY_W     = merge_pkg::KEY_W,
  parameter int PAY_W     = merge_pkg::PAY_W,
  parameter int BASE_W    = merge_pkg::BASE_W
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [BASE_W-1:0]       base_i,
  input  logic                    sel_valid_i,
  input  logic [KEY_W-1:0]        sel_key_i,
  input  logic [NUM_BLK_W-1:0]    sel_blk_i,
  input  logic [PAY_W-1:0]        sel_pay_i,
  input  logic                    sel_last_i,
  input  logic                    out_ready_i,
  output logic                    sel_ready_o,
  output logic                    out_valid_o,
  output logic [BASE_W+KEY_W-1:0] out_time_o,
  output logic [NUM_BLK_W-1:0]    out_blk_o,
  output logic [PAY_W-1:0]        out_pay_o,
  output logic                    out_last_o
);

  logic vld_q;

  assign sel_ready_o = !vld_q || out_ready_i;  // empty or draining this cycle
  assign out_valid_o = vld_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      vld_q <= 1'b0;
    else if (sel_ready_o)
      vld_q <= sel_valid_i;
  end

  always_ff @(posedge clk) begin
    if (sel_ready_o && sel_valid_i) begin
      out_time_o <= {base_i, sel_key_i};  // absolute time
      out_blk_o  <= sel_blk_i;           // block index as space index
      out_pay_o  <= sel_pay_i;
      out_last_o <= sel_last_i;
    end
  end

  // selector keeps its offer while stalled
  a_sel_hold: assert property (@(posedge clk) disable iff (rst)
    (sel_valid_i && !sel_ready_o) |=>
      (sel_valid_i && $stable({sel_key_i, sel_blk_i, sel_pay_i, sel_last_i})));

endmodule
